// File: Makefile
# Verilator lint and simulation of the pipelined adder testbench

VERILATOR  = verilator
TOP        = tb_pipelined_adder
FILELIST   = pipelined_adder.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -j 0
PASS_MSG   = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only if the pass message shows up on a line of its own
sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: lane_if.sv
// One slice lane of the adder pipeline, from operand skew through stage to deskew
`timescale 1ns/1ns

interface lane_if;

	// Operand slices, already skewed to this lane's cycle
	lf_adder_pkg::slice_t a;
	lf_adder_pkg::slice_t b;

	// Registered stage result
	lf_adder_pkg::slice_t sum;
	logic                 carry;

	modport skew (
		output a,
		output b
	);

	modport stage (
		input  a,
		input  b,
		output sum,
		output carry
	);

	// Carry is only taken from the last lane
	modport deskew (
		input sum,
		input carry
	);

endinterface

// File: lf_adder_pkg.sv
// Widths and vector types shared by the pipelined adder RTL and its testbench
package lf_adder_pkg;

	// Bits handled by one Ladner-Fischer slice
	localparam int slice_w = 10;

	// Slices per word, one pipeline stage each
	localparam int num_slices = 4;

	// Full operand and sum width
	localparam int word_w = slice_w * num_slices;

	// One operand or sum slice
	typedef logic [slice_w-1:0] slice_t;

	// Full operand or sum word
	typedef logic [word_w-1:0] word_t;

endpackage

// File: lf_slice_adder.sv
// Combinational 10-bit Ladner-Fischer prefix adder used inside each pipeline stage
`timescale 1ns/1ns

module lf_slice_adder (
	input  lf_adder_pkg::slice_t a,
	input  lf_adder_pkg::slice_t b,
	input  logic                 cin,
	output lf_adder_pkg::slice_t sum,
	output logic                 cout
);

	// Operand bits sit at 10:1 and g[0] holds the carry in
	logic [lf_adder_pkg::slice_w:1] p;
	logic [lf_adder_pkg::slice_w:0] g;

	// Ling pseudo-carries and true carries per bit
	logic [lf_adder_pkg::slice_w:1] h;
	logic [lf_adder_pkg::slice_w:1] c;

	// Group terms named by the bit span they cover
	logic h_1_0, h_3_2, h_5_4, h_7_6, h_9_8;
	logic i_3_2, i_5_4, i_7_6, i_9_8;
	logic h_3_0, h_7_4, i_7_4;
	logic h_5_0, h_7_0;
	logic h_9_0;
	logic h_2_0, h_4_0, h_6_0, h_8_0;

	// Pre-computation with an OR propagate so that g implies p
	assign p = a | b;
	assign g = {a & b, cin};

	// Stage 1 reduced cells on bit pairs
	assign h_1_0 = g[1] | g[0];
	assign h_3_2 = g[3] | g[2];
	assign i_3_2 = p[2] & p[1];
	assign h_5_4 = g[5] | g[4];
	assign i_5_4 = p[4] & p[3];
	assign h_7_6 = g[7] | g[6];
	assign i_7_6 = p[6] & p[5];
	assign h_9_8 = g[9] | g[8];
	assign i_9_8 = p[8] & p[7];

	// Stage 2
	assign h_3_0 = h_3_2 | (i_3_2 & h_1_0);
	assign h_7_4 = h_7_6 | (i_7_6 & h_5_4);
	assign i_7_4 = i_7_6 & i_5_4;

	// Stage 3
	assign h_5_0 = h_5_4 | (i_5_4 & h_3_0);
	assign h_7_0 = h_7_4 | (i_7_4 & h_3_0);

	// Stage 4 only reaches bit 9 inside this slice
	assign h_9_0 = h_9_8 | (i_9_8 & h_7_0);

	// Extra grey row fills in the even positions
	assign h_2_0 = g[2] | (p[1] & h_1_0);
	assign h_4_0 = g[4] | (p[3] & h_3_0);
	assign h_6_0 = g[6] | (p[5] & h_5_0);
	assign h_8_0 = g[8] | (p[7] & h_7_0);

	assign h[9:1] = {h_9_0, h_8_0, h_7_0, h_6_0, h_5_0, h_4_0, h_3_0, h_2_0, h_1_0};

	// True carry into bit k+1 is p[k] & h[k]
	assign c[1]    = g[0];
	assign c[10:2] = p[9:1] & h[9:1];

	// Post-computation
	assign h[10] = g[10] | c[10];
	assign sum   = (p[10:1] ^ h) | (g[10:1] & c);
	assign cout  = p[10] & h[10];

endmodule

// File: operand_skew.sv
// Cuts the operand words into slices and delays slice k by k cycles for its stage
`timescale 1ns/1ns

module operand_skew (
	input logic                clk,
	input logic                reset,
	input lf_adder_pkg::word_t a,
	input lf_adder_pkg::word_t b,
	lane_if.skew               lanes [lf_adder_pkg::num_slices]
);

	for (genvar k = 0; k < lf_adder_pkg::num_slices; k++) begin : g_lane
		if (k == 0) begin : g_direct
			// Lowest slice goes straight to stage 0
			assign lanes[k].a = a[k*lf_adder_pkg::slice_w +: lf_adder_pkg::slice_w];
			assign lanes[k].b = b[k*lf_adder_pkg::slice_w +: lf_adder_pkg::slice_w];
		end else begin : g_delay
			lf_adder_pkg::slice_t a_dly [k];
			lf_adder_pkg::slice_t b_dly [k];

			// k-deep shift chain
			always_ff @(posedge clk) begin
				if (reset) begin
					for (int i = 0; i < k; i++) begin
						a_dly[i] <= '0;
						b_dly[i] <= '0;
					end
				end else begin
					a_dly[0] <= a[k*lf_adder_pkg::slice_w +: lf_adder_pkg::slice_w];
					b_dly[0] <= b[k*lf_adder_pkg::slice_w +: lf_adder_pkg::slice_w];
					for (int i = 1; i < k; i++) begin
						a_dly[i] <= a_dly[i-1];
						b_dly[i] <= b_dly[i-1];
					end
				end
			end

			assign lanes[k].a = a_dly[k-1];
			assign lanes[k].b = b_dly[k-1];
		end
	end

endmodule

// File: pipelined_adder.f
lf_adder_pkg.sv
lane_if.sv
lf_slice_adder.sv
slice_stage.sv
operand_skew.sv
result_deskew.sv
pipelined_adder.sv
tb_pipelined_adder.sv

// File: pipelined_adder.sv
// Top level of the 40-bit pipelined adder, four cycles from operands to sum
`timescale 1ns/1ns

module pipelined_adder (
	input  logic                clk,
	input  logic                reset,
	input  logic                in_valid,
	input  lf_adder_pkg::word_t a,
	input  lf_adder_pkg::word_t b,
	input  logic                cin,
	output logic                out_valid,
	output lf_adder_pkg::word_t sum,
	output logic                cout
);

	lane_if lanes [lf_adder_pkg::num_slices] ();

	// Carry into each stage
	logic [lf_adder_pkg::num_slices-1:0] stage_cin;

	operand_skew operand_skew_inst (
		.clk   (clk),
		.reset (reset),
		.a     (a),
		.b     (b),
		.lanes (lanes)
	);

	assign stage_cin[0] = cin;

	// Ripple between stages through the stage registers
	for (genvar k = 1; k < lf_adder_pkg::num_slices; k++) begin : g_carry
		assign stage_cin[k] = lanes[k-1].carry;
	end

	for (genvar k = 0; k < lf_adder_pkg::num_slices; k++) begin : g_stage
		slice_stage slice_stage_inst (
			.clk      (clk),
			.reset    (reset),
			.lane     (lanes[k]),
			.carry_in (stage_cin[k])
		);
	end

	result_deskew result_deskew_inst (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.lanes     (lanes),
		.out_valid (out_valid),
		.sum       (sum),
		.cout      (cout)
	);

endmodule

// File: result_deskew.sv
// Realigns the lane sums into one output word and delays the valid strobe to match
`timescale 1ns/1ns

module result_deskew (
	input  logic                clk,
	input  logic                reset,
	input  logic                in_valid,
	lane_if.deskew              lanes [lf_adder_pkg::num_slices],
	output logic                out_valid,
	output lf_adder_pkg::word_t sum,
	output logic                cout
);

	// One flop per pipeline stage
	logic [lf_adder_pkg::num_slices-1:0] valid_dly;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_dly <= '0;
		end else begin
			valid_dly <= {valid_dly[lf_adder_pkg::num_slices-2:0], in_valid};
		end
	end

	assign out_valid = valid_dly[lf_adder_pkg::num_slices-1];

	for (genvar k = 0; k < lf_adder_pkg::num_slices; k++) begin : g_lane
		if (k == lf_adder_pkg::num_slices - 1) begin : g_direct
			// Top lane is already at the output cycle
			assign sum[k*lf_adder_pkg::slice_w +: lf_adder_pkg::slice_w] = lanes[k].sum;
		end else begin : g_delay
			lf_adder_pkg::slice_t sum_dly [lf_adder_pkg::num_slices-1-k];

			// Lower lanes finish early and wait here
			always_ff @(posedge clk) begin
				if (reset) begin
					for (int i = 0; i < lf_adder_pkg::num_slices - 1 - k; i++) begin
						sum_dly[i] <= '0;
					end
				end else begin
					sum_dly[0] <= lanes[k].sum;
					for (int i = 1; i < lf_adder_pkg::num_slices - 1 - k; i++) begin
						sum_dly[i] <= sum_dly[i-1];
					end
				end
			end

			assign sum[k*lf_adder_pkg::slice_w +: lf_adder_pkg::slice_w] =
				sum_dly[lf_adder_pkg::num_slices-2-k];
		end
	end

	// Carry out of the last stage register
	assign cout = lanes[lf_adder_pkg::num_slices-1].carry;

endmodule

// File: slice_stage.sv
// One adder pipeline stage that adds its lane slice and registers sum and carry
`timescale 1ns/1ns

module slice_stage (
	input logic   clk,
	input logic   reset,
	lane_if.stage lane,
	input logic   carry_in
);

	lf_adder_pkg::slice_t sum_next;
	logic                 carry_next;

	// carry_in is the previous stage's register, aligned with this lane's operands
	lf_slice_adder lf_slice_adder_inst (
		.a    (lane.a),
		.b    (lane.b),
		.cin  (carry_in),
		.sum  (sum_next),
		.cout (carry_next)
	);

	// Stage register, also the carry source for the next lane
	always_ff @(posedge clk) begin
		if (reset) begin
			lane.sum   <= '0;
			lane.carry <= 1'b0;
		end else begin
			lane.sum   <= sum_next;
			lane.carry <= carry_next;
		end
	end

endmodule

// File: tb_pipelined_adder.sv
// Self-checking random testbench for the pipelined adder, run as the simulation top
`timescale 1ns/1ns

module tb_pipelined_adder;

	localparam int latency = 4;
	localparam int reset_cycles = 3;
	localparam int idle_cycles = 5;
	localparam int num_random = 300;
	localparam int num_carry = 8;
	localparam int num_burst = 50;
	localparam int num_latency = 8;
	localparam int num_gap_pairs = 40;
	localparam int max_gap = 5;
	// One idle cycle plus the pipeline depth and a spare edge
	localparam int drain_cycles = latency + 2;
	localparam int num_drains = 4 + num_latency;
	// Longest possible run plus a margin of twenty
	localparam int max_cycles = reset_cycles + idle_cycles + num_random + num_carry
		+ num_burst + num_latency + num_gap_pairs * (1 + max_gap)
		+ num_drains * drain_cycles + 20;

	logic                clk;
	logic                reset;
	logic                in_valid;
	lf_adder_pkg::word_t a;
	lf_adder_pkg::word_t b;
	logic                cin;
	logic                out_valid;
	lf_adder_pkg::word_t sum;
	logic                cout;

	// Expected results in issue order
	lf_adder_pkg::word_t exp_sum_q [$];
	logic                exp_cout_q [$];
	int                  sent_cycle_q [$];
	string               test_q [$];

	int                  cycle;
	int                  in_count;
	int                  out_count;
	int                  burst_start;
	string               test_name;

	// Front entry taken by the checker
	lf_adder_pkg::word_t front_sum;
	logic                front_cout;
	int                  front_cycle;
	string               front_test;

	pipelined_adder pipelined_adder_inst (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.cin       (cin),
		.out_valid (out_valid),
		.sum       (sum),
		.cout      (cout)
	);

	always #5 clk = ~clk;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input lf_adder_pkg::word_t expected,
		input lf_adder_pkg::word_t actual);
		if (expected !== actual) begin
			report_failure($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (expected !== actual) begin
			report_failure($sformatf("ERROR %s: expected %b, actual %b", name, expected, actual));
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (expected != actual) begin
			report_failure($sformatf("ERROR %s: expected %0d, actual %0d", name, expected,
				actual));
		end
	endtask

	function automatic lf_adder_pkg::word_t random_word();
		return lf_adder_pkg::word_t'({$urandom(), $urandom()});
	endfunction

	function automatic logic random_bit();
		return ($urandom() % 2) == 1;
	endfunction

	// Model is the plain 41-bit sum a + b + cin
	task automatic drive_pair(input lf_adder_pkg::word_t op_a, input lf_adder_pkg::word_t op_b,
		input logic carry);
		logic [lf_adder_pkg::word_w:0] total;
		@(negedge clk);
		a = op_a;
		b = op_b;
		cin = carry;
		in_valid = 1'b1;
		total = {1'b0, op_a} + {1'b0, op_b} + {{lf_adder_pkg::word_w{1'b0}}, carry};
		exp_sum_q.push_back(total[lf_adder_pkg::word_w-1:0]);
		exp_cout_q.push_back(total[lf_adder_pkg::word_w]);
		sent_cycle_q.push_back(cycle);
		test_q.push_back(test_name);
		in_count++;
	endtask

	// Random data on idle cycles so stale operands cannot hide a bad strobe
	task automatic drive_idle();
		@(negedge clk);
		in_valid = 1'b0;
		a = random_word();
		b = random_word();
		cin = random_bit();
	endtask

	// Waits for outstanding results but never longer than the pipeline depth allows
	task automatic wait_drained();
		int waited;
		drive_idle();
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (exp_sum_q.size() != 0 && waited <= latency);
	endtask

	// Counts rising edges for the processes that sample on the falling edge
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= max_cycles) begin
			report_failure($sformatf("Timeout after %0d cycles with %0d results outstanding",
				cycle, exp_sum_q.size()));
		end
	end

	// Outputs are stable on the falling edge
	always @(negedge clk) begin
		if (out_valid) begin
			if (exp_sum_q.size() == 0) begin
				report_failure("A result came out with no input pending");
			end else begin
				front_sum = exp_sum_q.pop_front();
				front_cout = exp_cout_q.pop_front();
				front_cycle = sent_cycle_q.pop_front();
				front_test = test_q.pop_front();
				check_word({front_test, " sum"}, front_sum, sum);
				check_bit({front_test, " cout"}, front_cout, cout);
				check_count({front_test, " latency"}, latency, cycle - front_cycle);
				out_count++;
			end
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		a = '0;
		b = '0;
		cin = 1'b0;
		cycle = 0;
		in_count = 0;
		out_count = 0;
		test_name = "reset";
		void'($urandom(32'he591_d5c1));

		// No strobe during or right after reset
		repeat (reset_cycles) begin
			@(negedge clk);
			check_bit("reset out_valid", 1'b0, out_valid);
		end
		reset = 1'b0;
		repeat (idle_cycles) begin
			drive_idle();
			check_bit("post-reset out_valid", 1'b0, out_valid);
		end

		test_name = "random sum";
		repeat (num_random) begin
			drive_pair(random_word(), random_word(), random_bit());
		end
		wait_drained();

		// Carries that must ripple across every slice boundary
		test_name = "carry propagation";
		drive_pair('1, '0, 1'b1);
		drive_pair('1, '1, 1'b1);
		drive_pair({4{10'h155}}, {4{10'h2aa}}, 1'b1);
		drive_pair({4{10'h2aa}}, {4{10'h155}}, 1'b0);
		drive_pair('1, 40'h1, 1'b0);
		drive_pair('0, '0, 1'b1);
		drive_pair({10'h000, 10'h3ff, 10'h3ff, 10'h3ff}, 40'h1, 1'b0);
		drive_pair({10'h3ff, 10'h000, 10'h3ff, 10'h000},
			{10'h000, 10'h3ff, 10'h000, 10'h3ff}, 1'b1);
		wait_drained();

		test_name = "burst";
		burst_start = out_count;
		repeat (num_burst) begin
			drive_pair(random_word(), random_word(), random_bit());
		end
		wait_drained();
		check_count("burst result count", num_burst, out_count - burst_start);

		test_name = "latency";
		repeat (num_latency) begin
			drive_pair(random_word(), random_word(), random_bit());
			wait_drained();
		end

		test_name = "idle gaps";
		repeat (num_gap_pairs) begin
			drive_pair(random_word(), random_word(), random_bit());
			repeat ($urandom() % (max_gap + 1)) begin
				drive_idle();
			end
		end
		wait_drained();

		check_count("result count", in_count, out_count);
		check_count("pending results", 0, exp_sum_q.size());
		$display("No errors");
		$finish;
	end

endmodule
